/* valu_pkg.sv */
package valu_pkg;

    localparam int DATA_W_DEF = 64;
    localparam int ADDR_W_DEF = 32;
    localparam int VL_W_DEF   = 8;
    localparam int PIPE_LAT   = 2;           // Request to response, in cycles

    typedef enum logic [1:0] {SEW8, SEW16, SEW32, SEW64} sew_e;

    typedef enum logic [2:0] {OP_IVV = 3'd0, OP_MVV = 3'd2} op_mnr_e;

    // IVV and MVV share the code space, so codes repeat across the two groups
    typedef logic [5:0] func_e;

    localparam func_e FN_ADD     = 6'h00;
    localparam func_e FN_SUB     = 6'h02;
    localparam func_e FN_MINU    = 6'h04;
    localparam func_e FN_MIN     = 6'h05;
    localparam func_e FN_MAXU    = 6'h06;
    localparam func_e FN_MAX     = 6'h07;
    localparam func_e FN_AND     = 6'h09;
    localparam func_e FN_OR      = 6'h0a;
    localparam func_e FN_XOR     = 6'h0b;

    localparam func_e FN_REDSUM  = 6'h00;
    localparam func_e FN_REDAND  = 6'h01;
    localparam func_e FN_REDOR   = 6'h02;
    localparam func_e FN_REDXOR  = 6'h03;
    localparam func_e FN_REDMINU = 6'h04;
    localparam func_e FN_REDMIN  = 6'h05;
    localparam func_e FN_REDMAXU = 6'h06;
    localparam func_e FN_REDMAX  = 6'h07;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_MINU, ALU_MIN, ALU_MAXU, ALU_MAX
    } alu_op_e;

    function automatic logic [63:0] sew_mask(sew_e sew);
        case (sew)
            SEW8:    return 64'h0000_0000_0000_00ff;
            SEW16:   return 64'h0000_0000_0000_ffff;
            SEW32:   return 64'h0000_0000_ffff_ffff;
            default: return 64'hffff_ffff_ffff_ffff;
        endcase
    endfunction

    // One element operation, operands right aligned in a 64-bit container
    function automatic logic [63:0] elem_op(alu_op_e op, sew_e sew, logic [63:0] a,
                                            logic [63:0] b);
        logic [63:0] mask;
        logic [63:0] sign;
        logic        lt_u;
        logic        lt_s;
        logic [63:0] r;
        mask = sew_mask(sew);
        sign = mask ^ (mask >> 1);           // Top bit of the element
        lt_u = (a & mask) < (b & mask);
        lt_s = ((a ^ sign) & mask) < ((b ^ sign) & mask);  // Offset binary compare
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_MINU: r = lt_u ? a : b;
            ALU_MIN:  r = lt_s ? a : b;
            ALU_MAXU: r = lt_u ? b : a;
            ALU_MAX:  r = lt_s ? b : a;
            default:  r = a;
        endcase
        return r & mask;
    endfunction

endpackage

/* valu_decode.sv */
`timescale 1ns/1ps

module valu_decode (
    input  logic                req_valid,
    input  valu_pkg::op_mnr_e   req_op_mnr,
    input  valu_pkg::func_e     req_func_id,
    output logic                elem_valid,
    output logic                red_valid,
    output valu_pkg::alu_op_e   op
);

    logic legal;

    always_comb begin
        legal = 1'b1;
        op    = valu_pkg::ALU_ADD;
        case (req_op_mnr)
            valu_pkg::OP_IVV: begin
                case (req_func_id)
                    valu_pkg::FN_ADD:  op = valu_pkg::ALU_ADD;
                    valu_pkg::FN_SUB:  op = valu_pkg::ALU_SUB;
                    valu_pkg::FN_MINU: op = valu_pkg::ALU_MINU;
                    valu_pkg::FN_MIN:  op = valu_pkg::ALU_MIN;
                    valu_pkg::FN_MAXU: op = valu_pkg::ALU_MAXU;
                    valu_pkg::FN_MAX:  op = valu_pkg::ALU_MAX;
                    valu_pkg::FN_AND:  op = valu_pkg::ALU_AND;
                    valu_pkg::FN_OR:   op = valu_pkg::ALU_OR;
                    valu_pkg::FN_XOR:  op = valu_pkg::ALU_XOR;
                    default:           legal = 1'b0;
                endcase
            end
            valu_pkg::OP_MVV: begin
                case (req_func_id)
                    valu_pkg::FN_REDSUM:  op = valu_pkg::ALU_ADD;
                    valu_pkg::FN_REDAND:  op = valu_pkg::ALU_AND;
                    valu_pkg::FN_REDOR:   op = valu_pkg::ALU_OR;
                    valu_pkg::FN_REDXOR:  op = valu_pkg::ALU_XOR;
                    valu_pkg::FN_REDMINU: op = valu_pkg::ALU_MINU;
                    valu_pkg::FN_REDMIN:  op = valu_pkg::ALU_MIN;
                    valu_pkg::FN_REDMAXU: op = valu_pkg::ALU_MAXU;
                    valu_pkg::FN_REDMAX:  op = valu_pkg::ALU_MAX;
                    default:              legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        elem_valid = req_valid & legal & (req_op_mnr == valu_pkg::OP_IVV);
        red_valid  = req_valid & legal & (req_op_mnr == valu_pkg::OP_MVV);
    end

endmodule

/* lane_alu.sv */
`timescale 1ns/1ps

module lane_alu #(
    parameter int DATA_W = valu_pkg::DATA_W_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  valu_pkg::alu_op_e   op,
    input  valu_pkg::sew_e      sew,
    input  logic [DATA_W-1:0]   vec0,
    input  logic [DATA_W-1:0]   vec1,
    output logic                out_valid,
    output logic [DATA_W-1:0]   out_vec
);

    // Full-width result for each element width, selected by sew below
    wire [DATA_W-1:0] sew_res [4];

    for (genvar gs = 0; gs < 4; gs++) begin : g_sew
        localparam int LW = 8 << gs;
        localparam int NL = DATA_W / LW;

        for (genvar l = 0; l < NL; l++) begin : g_lane
            wire [63:0] a;
            wire [63:0] b;
            wire [63:0] r;

            assign a = 64'(vec0[l*LW +: LW]);
            assign b = 64'(vec1[l*LW +: LW]);
            assign r = valu_pkg::elem_op(op, valu_pkg::sew_e'(gs), a, b);  // No carry out of lane
            assign sew_res[gs][l*LW +: LW] = r[LW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_vec   <= '0;
        end else begin
            out_valid <= in_valid;
            out_vec   <= in_valid ? sew_res[sew] : '0;
        end
    end

endmodule

/* red_seq.sv */
`timescale 1ns/1ps

module red_seq (
    input  logic clk,
    input  logic rst,
    input  logic beat_valid,
    input  logic beat_start,
    input  logic beat_end,
    output logic acc_load,
    output logic acc_step,
    output logic acc_emit
);

    typedef enum logic {IDLE, ACCUM} state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        acc_load  = beat_valid & beat_start;                          // Also restarts an open one
        acc_step  = beat_valid & ~beat_start & (state == ACCUM);
        acc_emit  = (acc_load | acc_step) & beat_end;
        state_nxt = state;
        if (acc_load || acc_step) begin
            state_nxt = beat_end ? IDLE : ACCUM;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* red_acc.sv */
`timescale 1ns/1ps

module red_acc #(
    parameter int DATA_W = valu_pkg::DATA_W_DEF,
    localparam int BE_W  = DATA_W / 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                acc_load,
    input  logic                acc_step,
    input  logic                acc_emit,
    input  valu_pkg::alu_op_e   op,
    input  valu_pkg::sew_e      sew,
    input  logic [DATA_W-1:0]   vec0,
    input  logic [DATA_W-1:0]   vec1,
    input  logic [BE_W-1:0]     be,
    output logic                res_valid,
    output logic [DATA_W-1:0]   res_vec,
    output logic [BE_W-1:0]     res_be
);

    valu_pkg::alu_op_e op_q;
    valu_pkg::alu_op_e eff_op;
    valu_pkg::sew_e    sew_q;
    valu_pkg::sew_e    eff_sew;
    logic [63:0]       acc_q;
    logic [63:0]       mask;
    logic [63:0]       base;
    logic [63:0]       acc_next;
    logic [63:0]       node [BE_W];

    // Value that leaves the other operand unchanged
    function automatic logic [63:0] ident(valu_pkg::alu_op_e f, logic [63:0] m);
        case (f)
            valu_pkg::ALU_AND, valu_pkg::ALU_MINU: return m;
            valu_pkg::ALU_MIN:                     return m >> 1;
            valu_pkg::ALU_MAX:                     return m ^ (m >> 1);
            default:                               return '0;
        endcase
    endfunction

    always_comb begin
        if (acc_load) begin
            eff_op  = op;
            eff_sew = sew;
        end else begin
            eff_op  = op_q;
            eff_sew = sew_q;
        end
        mask = valu_pkg::sew_mask(eff_sew);
        base = acc_load ? (vec1[63:0] & mask) : acc_q;   // Seed from element 0 of vec1
        for (int i = 0; i < BE_W; i++) begin
            node[i] = ident(eff_op, mask);
            if ((i < (BE_W >> eff_sew)) && be[i << eff_sew]) begin
                node[i] = 64'(vec0 >> (i * (8 << eff_sew))) & mask;
            end
        end
        // Pairwise tree over the beat's elements
        for (int s = 1; s < BE_W; s = s * 2) begin
            for (int i = 0; i + s < BE_W; i += 2 * s) begin
                node[i] = valu_pkg::elem_op(eff_op, eff_sew, node[i], node[i+s]);
            end
        end
        acc_next = valu_pkg::elem_op(eff_op, eff_sew, base, node[0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            op_q      <= valu_pkg::ALU_ADD;
            sew_q     <= valu_pkg::SEW8;
        end else begin
            res_valid <= acc_emit;
            if (acc_load) begin
                op_q  <= op;
                sew_q <= sew;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_load || acc_step) begin
            acc_q <= acc_next;
        end
        if (acc_emit) begin
            res_vec <= DATA_W'(acc_next);                     // Element 0, rest zero
            res_be  <= BE_W'((1 << (1 << eff_sew)) - 1);
        end
    end

endmodule

/* side_pipe.sv */
`timescale 1ns/1ps

module side_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

/* resp_mux.sv */
`timescale 1ns/1ps

module resp_mux #(
    parameter int DATA_W = valu_pkg::DATA_W_DEF,
    parameter int ADDR_W = valu_pkg::ADDR_W_DEF,
    parameter int VL_W   = valu_pkg::VL_W_DEF,
    localparam int BE_W  = DATA_W / 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              alu_valid,
    input  logic [DATA_W-1:0] alu_vec,
    input  logic              red_valid,
    input  logic [DATA_W-1:0] red_vec,
    input  logic [BE_W-1:0]   red_be,
    input  logic [ADDR_W-1:0] pipe_addr,
    input  logic [VL_W-1:0]   pipe_vl,
    input  logic [BE_W-1:0]   pipe_be,
    output logic              resp_valid,
    output logic [DATA_W-1:0] resp_data,
    output logic [ADDR_W-1:0] req_addr_out,
    output logic [VL_W-1:0]   req_vl_out,
    output logic [BE_W-1:0]   req_be_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= alu_valid | red_valid;   // Never both in one slot
        end
    end

    always_ff @(posedge clk) begin
        resp_data    <= red_valid ? red_vec : alu_vec;
        req_be_out   <= red_valid ? red_be : pipe_be;
        req_addr_out <= pipe_addr;
        req_vl_out   <= pipe_vl;
    end

endmodule

/* valu_top.sv */
`timescale 1ns/1ps

module valu_top #(
    parameter int DATA_W = valu_pkg::DATA_W_DEF,
    parameter int ADDR_W = valu_pkg::ADDR_W_DEF,
    parameter int VL_W   = valu_pkg::VL_W_DEF,
    localparam int BE_W  = DATA_W / 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  valu_pkg::op_mnr_e   req_op_mnr,
    input  valu_pkg::func_e     req_func_id,
    input  valu_pkg::sew_e      req_sew,
    input  logic [DATA_W-1:0]   req_data0,
    input  logic [DATA_W-1:0]   req_data1,
    input  logic [ADDR_W-1:0]   req_addr,
    input  logic [BE_W-1:0]     req_be,
    input  logic [VL_W-1:0]     req_vl,
    input  logic                req_start,
    input  logic                req_end,
    output logic                req_ready,
    output logic                resp_valid,
    output logic [DATA_W-1:0]   resp_data,
    output logic [ADDR_W-1:0]   req_addr_out,
    output logic [VL_W-1:0]     req_vl_out,
    output logic [BE_W-1:0]     req_be_out
);

    localparam int SIDE_DEPTH = valu_pkg::PIPE_LAT - 1;   // resp_mux adds the last stage

    logic              elem_valid;
    logic              red_valid;
    valu_pkg::alu_op_e op;
    logic              alu_valid;
    logic [DATA_W-1:0] alu_vec;
    logic              acc_load;
    logic              acc_step;
    logic              acc_emit;
    logic              red_res_valid;
    logic [DATA_W-1:0] red_vec;
    logic [BE_W-1:0]   red_be;
    logic [ADDR_W-1:0] pipe_addr;
    logic [VL_W-1:0]   pipe_vl;
    logic [BE_W-1:0]   pipe_be;

    assign req_ready = 1'b1;   // No back-pressure

    valu_decode decode_i (
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .elem_valid  (elem_valid),
        .red_valid   (red_valid),
        .op          (op)
    );

    lane_alu #(.DATA_W(DATA_W)) lane_alu_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (elem_valid),
        .op        (op),
        .sew       (req_sew),
        .vec0      (req_data0),
        .vec1      (req_data1),
        .out_valid (alu_valid),
        .out_vec   (alu_vec)
    );

    red_seq red_seq_i (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (red_valid),
        .beat_start (req_start),
        .beat_end   (req_end),
        .acc_load   (acc_load),
        .acc_step   (acc_step),
        .acc_emit   (acc_emit)
    );

    red_acc #(.DATA_W(DATA_W)) red_acc_i (
        .clk       (clk),
        .rst       (rst),
        .acc_load  (acc_load),
        .acc_step  (acc_step),
        .acc_emit  (acc_emit),
        .op        (op),
        .sew       (req_sew),
        .vec0      (req_data0),
        .vec1      (req_data1),
        .be        (req_be),
        .res_valid (red_res_valid),
        .res_vec   (red_vec),
        .res_be    (red_be)
    );

    side_pipe #(.payload_t(logic [ADDR_W-1:0]), .DEPTH(SIDE_DEPTH)) addr_pipe_i (
        .clk (clk),
        .rst (rst),
        .d   (req_addr),
        .q   (pipe_addr)
    );

    side_pipe #(.payload_t(logic [VL_W-1:0]), .DEPTH(SIDE_DEPTH)) vl_pipe_i (
        .clk (clk),
        .rst (rst),
        .d   (req_vl),
        .q   (pipe_vl)
    );

    side_pipe #(.payload_t(logic [BE_W-1:0]), .DEPTH(SIDE_DEPTH)) be_pipe_i (
        .clk (clk),
        .rst (rst),
        .d   (req_be),
        .q   (pipe_be)
    );

    resp_mux #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .VL_W(VL_W)) resp_mux_i (
        .clk          (clk),
        .rst          (rst),
        .alu_valid    (alu_valid),
        .alu_vec      (alu_vec),
        .red_valid    (red_res_valid),
        .red_vec      (red_vec),
        .red_be       (red_be),
        .pipe_addr    (pipe_addr),
        .pipe_vl      (pipe_vl),
        .pipe_be      (pipe_be),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .req_addr_out (req_addr_out),
        .req_vl_out   (req_vl_out),
        .req_be_out   (req_be_out)
    );

endmodule

/* valu_checker.sv */
`timescale 1ns/1ps

module valu_checker (
    input  logic        clk,
    input  logic        rst,
    input  int unsigned cyc,
    input  logic        resp_valid,
    input  logic [63:0] resp_data,
    input  logic [31:0] req_addr_out,
    input  logic [7:0]  req_vl_out,
    input  logic [7:0]  req_be_out
);

    int unsigned due_q [$];          // Cycle count at which each response is due
    logic [63:0] data_q [$];
    logic [31:0] addr_q [$];
    logic [7:0]  vl_q [$];
    logic [7:0]  be_q [$];
    int          err_total = 0;
    int          test_err = 0;
    int          test_resp = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          resp_total = 0;

    task automatic expect_resp(int unsigned due, logic [63:0] data, logic [31:0] addr,
                               logic [7:0] vl, logic [7:0] be);
        due_q.push_back(due);
        data_q.push_back(data);
        addr_q.push_back(addr);
        vl_q.push_back(vl);
        be_q.push_back(be);
    endtask

    function automatic int pending();
        return due_q.size();
    endfunction

    task automatic count_error();
        test_err++;
        err_total++;
    endtask

    task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
            count_error();
        end
    endtask

    task automatic drop_front();
        void'(due_q.pop_front());
        void'(data_q.pop_front());
        void'(addr_q.pop_front());
        void'(vl_q.pop_front());
        void'(be_q.pop_front());
    endtask

    // Sampled mid-cycle, well away from the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (resp_valid === 1'b1) begin
                if (due_q.size() != 0 && due_q[0] == cyc) begin
                    compare("resp_data", resp_data, data_q[0]);
                    compare("req_addr_out", req_addr_out, addr_q[0]);
                    compare("req_vl_out", req_vl_out, vl_q[0]);
                    compare("req_be_out", req_be_out, be_q[0]);
                    test_resp++;
                    drop_front();
                end else begin
                    $display("Unexpected response at cycle %0d", cyc);
                    count_error();
                end
            end else if (resp_valid !== 1'b0) begin
                $display("resp_valid is unknown at cycle %0d", cyc);
                count_error();
            end
            while (due_q.size() != 0 && due_q[0] <= cyc) begin
                $display("Missing response that was due at cycle %0d", due_q[0]);
                count_error();
                drop_front();
            end
        end
    end

    task automatic end_test(string name);
        tests_run++;
        resp_total += test_resp;
        if (test_err != 0) begin
            tests_failed++;
        end
        $display("Test %s: %0d responses, %0d errors, %s", name, test_resp, test_err,
                 (test_err == 0) ? "PASS" : "FAIL");
        test_err  = 0;
        test_resp = 0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d tests, %0d failed, %0d responses checked, %0d errors",
                 tests_run, tests_failed, resp_total, err_total);
    endtask

endmodule

/* valu_assertions.sv */
`timescale 1ns/1ps

module valu_assertions (
    input logic clk,
    input logic rst,
    input logic req_ready,
    input logic resp_valid,
    input logic elem_valid
);

    int fail_count = 0;

    ready_high: assert property (@(posedge clk) req_ready)
        else begin
            $error("req_ready is low");
            fail_count++;
        end

    resp_quiet_in_reset: assert property (@(posedge clk) rst |=> !resp_valid)
        else begin
            $error("resp_valid high during or right after reset");
            fail_count++;
        end

    // Lane ALU stage plus response register
    elem_to_resp: assert property (@(posedge clk) disable iff (rst)
                                   elem_valid |-> ##2 resp_valid)
        else begin
            $error("Element-wise request without response two cycles later");
            fail_count++;
        end

endmodule

bind valu_top valu_assertions valu_assertions_i (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .elem_valid (elem_valid)
);

/* tb_valu_top.sv */
`timescale 1ns/1ps

module tb_valu_top;

    localparam int LAT = valu_pkg::PIPE_LAT;

    logic              clk;
    logic              rst;
    logic              req_valid;
    valu_pkg::op_mnr_e req_op_mnr;
    valu_pkg::func_e   req_func_id;
    valu_pkg::sew_e    req_sew;
    logic [63:0]       req_data0;
    logic [63:0]       req_data1;
    logic [31:0]       req_addr;
    logic [7:0]        req_be;
    logic [7:0]        req_vl;
    logic              req_start;
    logic              req_end;
    logic              req_ready;
    logic              resp_valid;
    logic [63:0]       resp_data;
    logic [31:0]       req_addr_out;
    logic [7:0]        req_vl_out;
    logic [7:0]        req_be_out;
    int unsigned       cyc = 0;
    logic              red_open;     // Reduction model state
    logic [63:0]       red_val;
    int                red_k;
    int                red_w;
    bit                timed_out;

    valu_top valu_top_i (.*);

    valu_checker valu_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Op index k counts up through add, sub, and, or, xor, minu, min, maxu, max
    function automatic logic [63:0] lane_ref(int k, int w, logic [63:0] a, logic [63:0] b);
        logic [63:0]        m;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        r;
        m  = (w == 64) ? '1 : (64'd1 << w) - 1;
        a  = a & m;
        b  = b & m;
        sa = a << (64 - w);                  // Element sign lands on bit 63
        sb = b << (64 - w);
        case (k)
            0:       r = a + b;
            1:       r = a - b;
            2:       r = a & b;
            3:       r = a | b;
            4:       r = a ^ b;
            5:       r = (a < b) ? a : b;
            6:       r = (sa < sb) ? a : b;
            7:       r = (a > b) ? a : b;
            default: r = (sa > sb) ? a : b;
        endcase
        return r & m;
    endfunction

    function automatic valu_pkg::func_e func_code(int k, bit red);
        case (k)
            0:       return red ? valu_pkg::FN_REDSUM : valu_pkg::FN_ADD;
            1:       return valu_pkg::FN_SUB;
            2:       return red ? valu_pkg::FN_REDAND : valu_pkg::FN_AND;
            3:       return red ? valu_pkg::FN_REDOR : valu_pkg::FN_OR;
            4:       return red ? valu_pkg::FN_REDXOR : valu_pkg::FN_XOR;
            5:       return red ? valu_pkg::FN_REDMINU : valu_pkg::FN_MINU;
            6:       return red ? valu_pkg::FN_REDMIN : valu_pkg::FN_MIN;
            7:       return red ? valu_pkg::FN_REDMAXU : valu_pkg::FN_MAXU;
            default: return red ? valu_pkg::FN_REDMAX : valu_pkg::FN_MAX;
        endcase
    endfunction

    function automatic logic [63:0] sign_bits(int w);
        logic [63:0] s;
        s = '0;
        for (int l = 0; l < 64 / w; l++) begin
            s[l * w + w - 1] = 1'b1;
        end
        return s;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    // One legal request; red marks a reduction beat
    task automatic send(int k, int s, bit red, bit first, bit last, logic [63:0] d0,
                        logic [63:0] d1);
        logic [31:0] addr;
        logic [7:0]  be;
        logic [7:0]  vl;
        logic [63:0] res;
        int          w;
        addr = $urandom;
        be   = $urandom;
        vl   = $urandom;
        w    = 8 << s;
        @(posedge clk);
        req_valid   <= 1'b1;
        req_op_mnr  <= red ? valu_pkg::OP_MVV : valu_pkg::OP_IVV;
        req_func_id <= func_code(k, red);
        req_sew     <= valu_pkg::sew_e'(s);
        req_data0   <= d0;
        req_data1   <= d1;
        req_addr    <= addr;
        req_be      <= be;
        req_vl      <= vl;
        req_start   <= first;
        req_end     <= last;
        if (!red) begin
            res = '0;
            for (int l = 0; l < 64 / w; l++) begin
                res |= lane_ref(k, w, d0 >> (l * w), d1 >> (l * w)) << (l * w);
            end
            valu_checker_i.expect_resp(cyc + 1 + LAT, res, addr, vl, be);
        end else begin
            if (first) begin
                red_open = 1'b1;
                red_k    = k;
                red_w    = w;
                red_val  = lane_ref(2, w, d1, '1);      // Element 0 of data1
            end
            if (red_open) begin
                for (int l = 0; l < 64 / red_w; l++) begin
                    if (be[l * red_w / 8]) begin
                        red_val = lane_ref(red_k, red_w, red_val, d0 >> (l * red_w));
                    end
                end
                if (last) begin
                    valu_checker_i.expect_resp(cyc + 1 + LAT, red_val, addr, vl,
                                               8'((16'd1 << (red_w / 8)) - 1));
                    red_open = 1'b0;
                end
            end
        end
    endtask

    task automatic send_illegal(int mnr, int fn);
        @(posedge clk);
        req_valid   <= 1'b1;
        req_op_mnr  <= valu_pkg::op_mnr_e'(mnr);
        req_func_id <= valu_pkg::func_e'(fn);
        req_data0   <= rand64();
        req_start   <= 1'b1;
        req_end     <= 1'b1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        req_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst      <= 1'b0;
        red_open = 1'b0;
    endtask

    // Drains the expected responses, then leaves a quiet gap for strays
    task automatic finish_test(string name);
        int t;
        t = 0;
        idle(1);
        while (valu_checker_i.pending() != 0 && t < 20) begin
            idle(1);
            t++;
        end
        if (valu_checker_i.pending() != 0) begin
            $display("Timeout waiting for responses in test %s", name);
            timed_out = 1'b1;
        end
        idle(LAT + 2);
        valu_checker_i.end_test(name);
    endtask

    initial begin
        int          k;
        int          s;
        int          n;
        logic [63:0] a;
        logic [63:0] b;
        void'($urandom(32'h625b_f9dc));
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op_mnr  = valu_pkg::OP_IVV;
        req_func_id = '0;
        req_sew     = valu_pkg::SEW8;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        red_open    = 1'b0;
        timed_out   = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 40; i++) begin
            send($urandom_range(0, 1), $urandom_range(0, 3), 1'b0, 1'b0, 1'b0, rand64(), rand64());
        end
        finish_test("add_sub");

        for (int i = 0; i < 40; i++) begin
            send($urandom_range(2, 4), $urandom_range(0, 3), 1'b0, 1'b0, 1'b0, rand64(), rand64());
        end
        finish_test("logic");

        for (int i = 0; i < 40; i++) begin
            s = $urandom_range(0, 3);
            a = rand64();
            b = $urandom_range(0, 1) ? rand64() : a ^ (sign_bits(8 << s) & rand64());
            send($urandom_range(5, 8), s, 1'b0, 1'b0, 1'b0, a, b);
        end
        finish_test("min_max");

        for (int r = 0; r < 30; r++) begin
            k = $urandom_range(0, 7);
            k = (k == 0) ? 0 : k + 1;              // Sub has no reduction
            s = $urandom_range(0, 3);
            n = $urandom_range(1, 4);
            for (int j = 0; j < n; j++) begin
                send(k, s, 1'b1, j == 0, j == n - 1, rand64(), rand64());
                idle($urandom_range(0, 3) == 0);
            end
        end
        finish_test("reductions");

        apply_reset();
        send_illegal(0, 6'h01);
        send_illegal(0, 6'h3f);
        send_illegal(2, 6'h08);
        send_illegal(1, 6'h00);
        send_illegal(5, 6'h07);
        send(0, 2, 1'b1, 1'b0, 1'b1, rand64(), rand64());   // End beat while idle
        send(3, 1, 1'b1, 1'b0, 1'b0, rand64(), rand64());
        send(0, 0, 1'b1, 1'b1, 1'b0, rand64(), rand64());
        send(0, 0, 1'b1, 1'b0, 1'b0, rand64(), rand64());
        send(8, 3, 1'b1, 1'b1, 1'b0, rand64(), rand64());   // Restart drops the partial sum
        send(8, 3, 1'b1, 1'b0, 1'b1, rand64(), rand64());
        finish_test("illegal_and_restart");

        valu_checker_i.print_summary();
        if (!timed_out && valu_checker_i.err_total == 0 &&
            valu_top_i.valu_assertions_i.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* valu_top.f */
valu_pkg.sv
valu_decode.sv
lane_alu.sv
red_seq.sv
red_acc.sv
side_pipe.sv
resp_mux.sv
valu_top.sv
valu_checker.sv
valu_assertions.sv
tb_valu_top.sv
